// File: design/motor_pkg.sv
package motor_pkg;

    // **********************************************************
    // Vector types shared across the drive
    // **********************************************************

    // Step period counted in prescaler ticks
    typedef logic [9:0] freq_t;

    typedef logic [2:0] step_t;    // Commutation step index, 0 to 5

    // One-hot phase select, bit 0 is A, bit 1 is B, bit 2 is C
    typedef logic [2:0] phase_t;

    typedef logic [7:0] byte_t;    // Serial payload

    // **********************************************************
    // Controller FSM
    // **********************************************************

    typedef enum logic [0:0] {
        ST_IDLE,
        ST_RUN
    } ctrl_state_t;

endpackage

// File: design/step_timer.sv
module step_timer
    import motor_pkg::*;
#(
    parameter int PRESCALE = 4
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  running,
    input  freq_t m3_freq,
    output logic  step_pulse
);

    localparam int PW = (PRESCALE > 1) ? $clog2(PRESCALE) : 1;

    logic [PW-1:0] pre_cnt;
    logic          tick;
    freq_t         tick_cnt;
    freq_t         tick_next;

    assign tick      = (pre_cnt == PW'(PRESCALE - 1));
    assign tick_next = tick_cnt + 1'b1;

    // Prescaler stands in for a slower motor clock
    always_ff @(posedge clk) begin
        if (rst || !running) begin
            pre_cnt <= '0;
        end else if (tick) begin
            pre_cnt <= '0;
        end else begin
            pre_cnt <= pre_cnt + 1'b1;
        end
    end

    // A zero frequency word never matches, so the motor holds its step
    always_ff @(posedge clk) begin
        if (rst || !running) begin
            tick_cnt   <= '0;
            step_pulse <= 1'b0;
        end else begin
            step_pulse <= 1'b0;
            if (tick) begin
                if (m3_freq != '0 && tick_next >= m3_freq) begin
                    tick_cnt   <= '0;
                    step_pulse <= 1'b1;
                end else begin
                    tick_cnt <= tick_next;    // Free wrap when m3_freq is 0
                end
            end
        end
    end

endmodule

// File: design/commutation_ctrl.sv
module commutation_ctrl
    import motor_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   m3_start,
    input  logic   m3_inv_or_stop,
    input  logic   step_pulse,
    output logic   running,
    output logic   reverse,
    output phase_t cmd_high,
    output phase_t cmd_low,
    output logic   rev_pulse,
    output byte_t  rev_count
);

    localparam phase_t PH_A = 3'b001;
    localparam phase_t PH_B = 3'b010;
    localparam phase_t PH_C = 3'b100;

    ctrl_state_t state;
    ctrl_state_t state_next;
    step_t       step;
    step_t       step_next;
    logic        reverse_next;
    logic        inv_prev;
    logic        stop_edge;
    logic        wrap;

    // Six-step table, high side in the upper three bits
    function automatic logic [5:0] comm_lookup(input step_t s);
        case (s)
            3'd0:    comm_lookup = {PH_A, PH_B};
            3'd1:    comm_lookup = {PH_A, PH_C};
            3'd2:    comm_lookup = {PH_B, PH_C};
            3'd3:    comm_lookup = {PH_B, PH_A};
            3'd4:    comm_lookup = {PH_C, PH_A};
            3'd5:    comm_lookup = {PH_C, PH_B};
            default: comm_lookup = '0;
        endcase
    endfunction

    assign stop_edge = m3_inv_or_stop && !inv_prev;
    assign running   = (state == ST_RUN);

    always_comb begin
        state_next   = state;
        reverse_next = reverse;
        step_next    = step;
        wrap         = 1'b0;
        case (state)
            ST_IDLE: begin
                if (m3_start) begin
                    state_next   = ST_RUN;
                    reverse_next = m3_inv_or_stop;    // Direction is sampled at start
                end
            end
            ST_RUN: begin
                if (stop_edge) begin
                    state_next = ST_IDLE;    // Step index is kept for a restart
                end else if (step_pulse) begin
                    if (reverse) begin
                        wrap      = (step == 3'd0);
                        step_next = wrap ? 3'd5 : step - 1'b1;
                    end else begin
                        wrap      = (step == 3'd5);
                        step_next = wrap ? 3'd0 : step + 1'b1;
                    end
                end
            end
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ST_IDLE;
            reverse   <= 1'b0;
            step      <= '0;
            inv_prev  <= 1'b0;
            cmd_high  <= '0;
            cmd_low   <= '0;
            rev_pulse <= 1'b0;
            rev_count <= '0;
        end else begin
            state     <= state_next;
            reverse   <= reverse_next;
            step      <= step_next;
            inv_prev  <= m3_inv_or_stop;
            rev_pulse <= wrap;
            if (state_next == ST_RUN) begin
                {cmd_high, cmd_low} <= comm_lookup(step_next);
            end else begin
                {cmd_high, cmd_low} <= '0;
            end
            if (wrap) begin
                rev_count <= rev_count + 1'b1;    // Pulse carries the new count
            end
        end
    end

endmodule

// File: design/gate_driver.sv
module gate_driver
    import motor_pkg::*;
#(
    parameter int DEAD_CYCLES = 3
) (
    input  logic   clk,
    input  logic   rst,
    input  phase_t cmd_high,
    input  phase_t cmd_low,
    output logic   a_h,
    output logic   a_l,
    output logic   b_h,
    output logic   b_l,
    output logic   c_h,
    output logic   c_l
);

    localparam int DW = (DEAD_CYCLES > 1) ? $clog2(DEAD_CYCLES) : 1;

    phase_t        last_high;
    phase_t        last_low;
    phase_t        high_q;
    phase_t        low_q;
    logic [DW-1:0] dead_cnt;
    logic          cmd_change;

    // Compare against the pair last accepted, not the pair on the pins
    assign cmd_change = (cmd_high != last_high) || (cmd_low != last_low);

    // **********************************************************
    // Dead-time blanking
    // **********************************************************

    // The change cycle counts as the first blanked cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            last_high <= '0;
            last_low  <= '0;
            dead_cnt  <= '0;
            high_q    <= '0;
            low_q     <= '0;
        end else if (cmd_change) begin
            last_high <= cmd_high;
            last_low  <= cmd_low;
            dead_cnt  <= DW'(DEAD_CYCLES - 1);    // Restarts on any new change
            high_q    <= '0;
            low_q     <= '0;
        end else if (dead_cnt != '0) begin
            dead_cnt <= dead_cnt - 1'b1;
            high_q   <= '0;
            low_q    <= '0;
        end else begin
            high_q <= last_high;
            low_q  <= last_low;
        end
    end

    // **********************************************************
    // Gate pins
    // **********************************************************

    assign a_h = high_q[0];
    assign b_h = high_q[1];
    assign c_h = high_q[2];
    assign a_l = low_q[0];
    assign b_l = low_q[1];
    assign c_l = low_q[2];

endmodule

// File: design/uart_tx.sv
module uart_tx
    import motor_pkg::*;
#(
    parameter int CLKS_PER_BIT = 8
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  rev_pulse,
    input  byte_t rev_count,
    output logic  rs232_tx,
    output logic  busy
);

    localparam int CW = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

    logic [CW-1:0] clk_cnt;
    logic [3:0]    bit_cnt;
    logic [8:0]    shift;    // Data bits with the stop bit above them
    logic          bit_end;

    assign bit_end = (clk_cnt == CW'(CLKS_PER_BIT - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            clk_cnt  <= '0;
            bit_cnt  <= '0;
            shift    <= '1;
            rs232_tx <= 1'b1;    // Line idles high
            busy     <= 1'b0;
        end else if (!busy) begin
            if (rev_pulse) begin
                shift    <= {1'b1, rev_count};
                clk_cnt  <= '0;
                bit_cnt  <= '0;
                rs232_tx <= 1'b0;    // Start bit
                busy     <= 1'b1;
            end
        end else if (bit_end) begin
            clk_cnt <= '0;
            if (bit_cnt == 4'd9) begin
                busy <= 1'b0;    // Stop bit has run its full time
            end else begin
                rs232_tx <= shift[0];    // LSB first
                shift    <= {1'b1, shift[8:1]};
                bit_cnt  <= bit_cnt + 1'b1;
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    // A strobe seen while busy is simply dropped

endmodule

// File: design/heartbeat_led.sv
module heartbeat_led #(
    parameter int HEARTBEAT_CYCLES = 50
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       running,
    input  logic       reverse,
    input  logic       busy,
    output logic [3:0] led4
);

    localparam int HW = (HEARTBEAT_CYCLES > 1) ? $clog2(HEARTBEAT_CYCLES) : 1;

    logic [HW-1:0] hb_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            hb_cnt <= '0;
            led4   <= '0;
        end else begin
            if (hb_cnt == HW'(HEARTBEAT_CYCLES - 1)) begin
                hb_cnt  <= '0;
                led4[0] <= ~led4[0];    // Blink shows the clock is alive
            end else begin
                hb_cnt <= hb_cnt + 1'b1;
            end
            // Status bits from run state up to transmitter activity
            led4[3:1] <= {busy, reverse, running};
        end
    end

endmodule

// File: design/motor_drive_top.sv
module motor_drive_top
    import motor_pkg::*;
#(
    parameter int PRESCALE         = 4,
    parameter int DEAD_CYCLES      = 3,
    parameter int CLKS_PER_BIT     = 8,
    parameter int HEARTBEAT_CYCLES = 50
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       m3_start,
    input  logic       m3_inv_or_stop,
    input  freq_t      m3_freq,
    output logic       a_h,
    output logic       a_l,
    output logic       b_h,
    output logic       b_l,
    output logic       c_h,
    output logic       c_l,
    output logic       rs232_tx,
    output logic [3:0] led4
);

    logic   running;
    logic   reverse;
    logic   step_pulse;
    phase_t cmd_high;
    phase_t cmd_low;
    logic   rev_pulse;
    byte_t  rev_count;
    logic   busy;

    step_timer #(
        .PRESCALE    (PRESCALE)
    ) i_step_timer (
        .clk         (clk),
        .rst         (rst),
        .running     (running),
        .m3_freq     (m3_freq),
        .step_pulse  (step_pulse)
    );

    commutation_ctrl i_commutation_ctrl (
        .clk            (clk),
        .rst            (rst),
        .m3_start       (m3_start),
        .m3_inv_or_stop (m3_inv_or_stop),
        .step_pulse     (step_pulse),
        .running        (running),
        .reverse        (reverse),
        .cmd_high       (cmd_high),
        .cmd_low        (cmd_low),
        .rev_pulse      (rev_pulse),
        .rev_count      (rev_count)
    );

    gate_driver #(
        .DEAD_CYCLES (DEAD_CYCLES)
    ) i_gate_driver (
        .clk         (clk),
        .rst         (rst),
        .cmd_high    (cmd_high),
        .cmd_low     (cmd_low),
        .a_h         (a_h),
        .a_l         (a_l),
        .b_h         (b_h),
        .b_l         (b_l),
        .c_h         (c_h),
        .c_l         (c_l)
    );

    uart_tx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) i_uart_tx (
        .clk          (clk),
        .rst          (rst),
        .rev_pulse    (rev_pulse),
        .rev_count    (rev_count),
        .rs232_tx     (rs232_tx),
        .busy         (busy)
    );

    heartbeat_led #(
        .HEARTBEAT_CYCLES (HEARTBEAT_CYCLES)
    ) i_heartbeat_led (
        .clk              (clk),
        .rst              (rst),
        .running          (running),
        .reverse          (reverse),
        .busy             (busy),
        .led4             (led4)
    );

endmodule

// File: test/motor_drive_props.sv
module motor_drive_props
    import motor_pkg::*;
#(
    parameter int DEAD_CYCLES = 3
) (
    input logic        clk,
    input logic        rst,
    input ctrl_state_t state,
    input logic        a_h,
    input logic        a_l,
    input logic        b_h,
    input logic        b_l,
    input logic        c_h,
    input logic        c_l
);

    phase_t gates_high;
    phase_t gates_low;
    int     idle_cnt;

    assign gates_high = {c_h, b_h, a_h};
    assign gates_low  = {c_l, b_l, a_l};

    // Cycles spent in ST_IDLE, saturating at the dead time
    always_ff @(posedge clk) begin
        if (rst || state != ST_IDLE) begin
            idle_cnt <= 0;
        end else if (idle_cnt < DEAD_CYCLES) begin
            idle_cnt <= idle_cnt + 1;
        end
    end

    phase_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(a_h && a_l) && !(b_h && b_l) && !(c_h && c_l))
        else $error("High and low switch of one phase are on together");

    single_pair: assert property (@(posedge clk) disable iff (rst)
        $countones(gates_high) <= 1 && $countones(gates_low) <= 1)
        else $error("More than one high or low gate is on");

    idle_gates_low: assert property (@(posedge clk) disable iff (rst)
        idle_cnt >= DEAD_CYCLES |-> (gates_high == '0 && gates_low == '0))
        else $error("Gates still driven after the controller went idle");

endmodule

// Watches the gate driver pins together with the controller state
bind motor_drive_top motor_drive_props #(
    .DEAD_CYCLES (DEAD_CYCLES)
) i_motor_drive_props (
    .clk   (clk),
    .rst   (rst),
    .state (i_commutation_ctrl.state),
    .a_h   (i_gate_driver.a_h),
    .a_l   (i_gate_driver.a_l),
    .b_h   (i_gate_driver.b_h),
    .b_l   (i_gate_driver.b_l),
    .c_h   (i_gate_driver.c_h),
    .c_l   (i_gate_driver.c_l)
);

// File: test/motor_drive_tb.sv
module motor_drive_tb
    import motor_pkg::*;
;

    localparam int PRESCALE         = 4;
    localparam int DEAD_CYCLES      = 3;
    localparam int CLKS_PER_BIT     = 8;
    localparam int HEARTBEAT_CYCLES = 50;
    localparam int REV_CYCLES       = 6 * 20 * PRESCALE;    // Slowest revolution
    localparam int MARGIN_CYCLES    = 400;
    localparam int WATCHDOG_CYCLES  = 5 * REV_CYCLES + 5 * MARGIN_CYCLES;

    logic       clk;
    logic       rst;
    logic       m3_start;
    logic       m3_inv_or_stop;
    freq_t      m3_freq;
    logic       a_h;
    logic       a_l;
    logic       b_h;
    logic       b_l;
    logic       c_h;
    logic       c_l;
    logic       rs232_tx;
    logic [3:0] led4;
    logic [5:0] pattern;
    logic [5:0] prev_pattern;
    logic [7:0] rx_byte;
    logic [7:0] serial_q[$];
    int         step_q[$];
    int         zero_run;
    bit         seen_pattern;
    int         errors;
    int         checks;
    int         exp_revs;

    motor_drive_top #(
        .PRESCALE         (PRESCALE),
        .DEAD_CYCLES      (DEAD_CYCLES),
        .CLKS_PER_BIT     (CLKS_PER_BIT),
        .HEARTBEAT_CYCLES (HEARTBEAT_CYCLES)
    ) i_motor_drive_top (
        .clk            (clk),
        .rst            (rst),
        .m3_start       (m3_start),
        .m3_inv_or_stop (m3_inv_or_stop),
        .m3_freq        (m3_freq),
        .a_h            (a_h),
        .a_l            (a_l),
        .b_h            (b_h),
        .b_l            (b_l),
        .c_h            (c_h),
        .c_l            (c_l),
        .rs232_tx       (rs232_tx),
        .led4           (led4)
    );

    assign pattern = {c_h, b_h, a_h, c_l, b_l, a_l};    // High side above low side

    always #5 clk = ~clk;

    // ************************************************************
    // Reference model and checking helpers
    // ************************************************************

    // Bit 0 of each half is phase A
    function automatic logic [5:0] table_pattern(input int s);
        case (s)
            0:       table_pattern = {3'b001, 3'b010};
            1:       table_pattern = {3'b001, 3'b100};
            2:       table_pattern = {3'b010, 3'b100};
            3:       table_pattern = {3'b010, 3'b001};
            4:       table_pattern = {3'b100, 3'b001};
            5:       table_pattern = {3'b100, 3'b010};
            default: table_pattern = '0;
        endcase
    endfunction

    function automatic int decode_step(input logic [5:0] p);
        int found;
        found = 7;
        for (int s = 0; s < 6; s++) begin
            if (table_pattern(s) == p) begin
                found = s;
            end
        end
        return found;
    endfunction

    // Walks the expected step sequence and counts index wraps
    function automatic int count_wraps(input int first, input bit rev, input int count);
        int n;
        int s;
        n = 0;
        s = first;
        for (int k = 1; k < count; k++) begin
            if (rev) begin
                if (s == 0) begin
                    n++;
                end
                s = (s + 5) % 6;
            end else begin
                if (s == 5) begin
                    n++;
                end
                s = (s + 1) % 6;
            end
        end
        return n;
    endfunction

    task automatic report_failure(input string what);
        errors++;
        $display("Error at %0t: %s", $time, what);
    endtask

    task automatic check_value(input string name, input int got, input int expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("ERR %s: got 0x%0h, expected 0x%0h", name, got, expected);
        end
    endtask

    // ************************************************************
    // Gate and serial monitors
    // ************************************************************

    always @(negedge clk) begin
        if (rst) begin
            prev_pattern = '0;
            zero_run     = 0;
            seen_pattern = 1'b0;
        end else begin
            if (pattern == '0) begin
                zero_run++;
            end else if (pattern != prev_pattern) begin
                if (prev_pattern != '0)
                    report_failure("gate pattern changed with no blanking gap");
                else if (seen_pattern && zero_run < DEAD_CYCLES)
                    report_failure($sformatf("dead time of only %0d cycles", zero_run));
                if (decode_step(pattern) == 7)
                    report_failure($sformatf("gate pattern %b is no commutation step", pattern));
                step_q.push_back(decode_step(pattern));
                seen_pattern = 1'b1;
                zero_run     = 0;
            end
            prev_pattern = pattern;
        end
    end

    always begin
        @(negedge clk);
        if (!rst && rs232_tx == 1'b0) begin
            repeat (CLKS_PER_BIT / 2 - 1) @(negedge clk);    // Middle of the start bit
            if (rs232_tx !== 1'b0) report_failure("start bit ended before mid-bit");
            for (int i = 0; i < 8; i++) begin
                repeat (CLKS_PER_BIT) @(negedge clk);
                rx_byte[i] = rs232_tx;
            end
            repeat (CLKS_PER_BIT) @(negedge clk);
            if (rs232_tx !== 1'b1) report_failure("serial frame has no stop bit");
            serial_q.push_back(rx_byte);
        end
    end

    // ************************************************************
    // Stimulus tasks
    // ************************************************************

    task automatic pulse_start();
        @(posedge clk);
        m3_start <= 1'b1;
        @(posedge clk);
        m3_start <= 1'b0;
    endtask

    task automatic stop_motor();
        @(posedge clk);
        m3_inv_or_stop <= 1'b0;
        @(posedge clk);
        m3_inv_or_stop <= 1'b1;    // Rising edge stops the drive
        repeat (DEAD_CYCLES + 4) @(posedge clk);
        @(negedge clk);
        check_value("gates after stop", int'(pattern), 0);
        check_value("led4[1] after stop", int'(led4[1]), 0);
    endtask

    task automatic wait_steps(input int count, input int budget);
        int waited;
        waited = 0;
        while (step_q.size() < count && waited < budget) begin
            @(posedge clk);
            waited++;
        end
        if (step_q.size() < count)
            report_failure($sformatf("only %0d of %0d gate steps seen", step_q.size(), count));
    endtask

    // All expected bytes in and the transmitter idle again
    task automatic wait_frames_done(input int budget);
        int waited;
        waited = 0;
        while ((serial_q.size() < exp_revs || led4[3]) && waited < budget) begin
            @(posedge clk);
            waited++;
        end
        if (serial_q.size() < exp_revs || led4[3])
            report_failure("serial transmitter did not finish its frames in time");
    endtask

    task automatic check_step_sequence(input int first, input bit rev, input int count);
        int n;
        n = (step_q.size() < count) ? step_q.size() : count;
        for (int k = 0; k < n; k++) begin
            if (rev)
                check_value($sformatf("step[%0d]", k), step_q[k], (first + 6 * count - k) % 6);
            else
                check_value($sformatf("step[%0d]", k), step_q[k], (first + k) % 6);
        end
    endtask

    // ************************************************************
    // Directed tests
    // ************************************************************

    task automatic after_reset_check();
        logic hb_level;
        @(negedge clk);
        check_value("gates", int'(pattern), 0);
        check_value("rs232_tx", int'(rs232_tx), 1);
        check_value("led4", int'(led4), 0);
        hb_level = led4[0];
        repeat (HEARTBEAT_CYCLES) @(negedge clk);    // Exactly one toggle in this window
        check_value("led4[0]", int'(led4[0]), int'(!hb_level));
    endtask

    task automatic forward_run();
        step_q.delete();
        @(posedge clk);
        m3_freq        <= freq_t'(4 + $urandom % 17);
        m3_inv_or_stop <= 1'b0;
        pulse_start();
        wait_steps(7, REV_CYCLES + MARGIN_CYCLES);
        check_step_sequence(0, 1'b0, 7);
        exp_revs += count_wraps(0, 1'b0, 7);
        @(negedge clk);
        check_value("led4[1]", int'(led4[1]), 1);
        check_value("led4[2]", int'(led4[2]), 0);
    endtask

    task automatic stop_and_reverse();
        int kept;
        kept = step_q[$];
        stop_motor();
        check_value("led4[3]", int'(led4[3]), 1);    // Frame of the last wrap is still going
        wait_frames_done(MARGIN_CYCLES);
        step_q.delete();
        pulse_start();    // Level is still high, so the restart runs in reverse
        wait_steps(7, REV_CYCLES + MARGIN_CYCLES);
        check_step_sequence(kept, 1'b1, 7);
        exp_revs += count_wraps(kept, 1'b1, 7);
        @(negedge clk);
        check_value("led4[2]", int'(led4[2]), 1);
        stop_motor();
    endtask

    task automatic revolution_reports();
        int kept;
        kept = step_q[$];
        step_q.delete();
        @(posedge clk);
        m3_freq        <= freq_t'(4 + $urandom % 17);
        m3_inv_or_stop <= 1'b0;
        pulse_start();
        wait_steps(13, 2 * REV_CYCLES + MARGIN_CYCLES);
        check_step_sequence(kept, 1'b0, 13);
        exp_revs += count_wraps(kept, 1'b0, 13);
        stop_motor();
        wait_frames_done(MARGIN_CYCLES);
        check_value("byte count", serial_q.size(), exp_revs);
        foreach (serial_q[i]) begin
            check_value($sformatf("rev byte %0d", i), int'(serial_q[i]), i + 1);
        end
    endtask

    task automatic zero_frequency_hold();
        int kept;
        int bytes_before;
        kept         = step_q[$];
        bytes_before = serial_q.size();
        step_q.delete();
        @(posedge clk);
        m3_freq        <= '0;
        m3_inv_or_stop <= 1'b0;
        pulse_start();
        wait_steps(1, MARGIN_CYCLES);
        repeat (REV_CYCLES) @(posedge clk);
        @(negedge clk);
        check_value("step count", step_q.size(), 1);
        check_value("held gates", int'(pattern), int'(table_pattern(kept)));
        check_value("byte count", serial_q.size(), bytes_before);
        stop_motor();
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, a test did not finish", WATCHDOG_CYCLES);
        $display("Regression failed");
        $finish;
    end

    initial begin
        errors         = 0;
        checks         = 0;
        exp_revs       = 0;
        void'($urandom(32'h76a23e5a));
        clk            = 1'b0;
        rst            = 1'b1;
        m3_start       = 1'b0;
        m3_inv_or_stop = 1'b0;
        m3_freq        = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        after_reset_check();
        forward_run();
        stop_and_reverse();
        revolution_reports();
        zero_frequency_hold();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: sources.f
design/motor_pkg.sv
design/step_timer.sv
design/commutation_ctrl.sv
design/gate_driver.sv
design/uart_tx.sv
design/heartbeat_led.sv
design/motor_drive_top.sv
test/motor_drive_props.sv
test/motor_drive_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the motor drive testbench with Verilator, runs it and judges the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir
SIM=motor_drive_sim

verilator --binary --timing --assert -f sources.f --top-module motor_drive_tb \
    -Mdir "$BUILD_DIR" -o "$SIM"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Regression failed" "$LOG"; then
    exit 1
fi
exit 0
